/* tb.f */
+incdir+tests
hw/pio_pkg.sv
hw/scratch_reg.sv
hw/operand_select.sv
hw/pin_unit.sv
hw/sm_control.sv
hw/pio_top.sv
tests/tb_top.sv

/* Makefile */
# Verilator build and run for the PIO testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation failed"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/pio_model.svh */
// Reference model of the PIO state machine
// Keeps its own pc, X, Y, pins, directions and delay and steps them once per edge

`ifndef PIO_MODEL_SVH
`define PIO_MODEL_SVH

pc_t    ref_pc;
word_t  ref_x;
word_t  ref_y;
word_t  ref_pins;
word_t  ref_dirs;
field_t ref_delay;

task automatic reset_model();
  ref_pc    = '0;
  ref_x     = '0;
  ref_y     = '0;
  ref_pins  = '0;
  ref_dirs  = '0;
  ref_delay = '0;
endtask

function automatic logic jump_condition(input arg_t cond, input logic jpin);
  case (cond)
    3'd0:    return 1'b1;
    3'd1:    return ref_x == 0;
    3'd2:    return ref_x != 0;      // Decrement follows if taken
    3'd3:    return ref_y == 0;
    3'd4:    return ref_y != 0;
    3'd5:    return ref_x != ref_y;
    3'd6:    return jpin;
    default: return 1'b0;            // Code 7 never jumps
  endcase
endfunction

function automatic word_t mov_source(input field_t sel, input word_t pins);
  word_t raw;
  word_t res;
  int    i;
  raw = '0;
  case (sel[2:0])
    3'd0: for (i = 0; i < 32; i++) raw[i] = pins[(i + in_base) % 32];
    3'd1: raw = ref_x;
    3'd2: raw = ref_y;
    default: raw = '0;
  endcase
  res = raw;
  if (sel[4:3] == 2'd1)
    res = ~raw;
  else if (sel[4:3] == 2'd2)
    for (i = 0; i < 32; i++) res[i] = raw[31 - i];
  return res;
endfunction

// Only the base/count group changes, wrapping past pin 31
function automatic word_t write_group(input word_t old, input word_t din);
  word_t res;
  int    i;
  res = old;
  for (i = 0; i < pins_count && i < 5; i++)
    res[(pins_base + i) % 32] = din[i];
  return res;
endfunction

function automatic logic wait_unmet(input instr_t ins, input word_t pins);
  return (ins[15:13] == 3'd1) && (pins[ins[4:0]] != ins[7]);  // Polarity in op1 bit 2
endfunction

function automatic logic expect_stalled(input instr_t ins, input word_t pins);
  return (ref_delay != 0) || wait_unmet(ins, pins);
endfunction

task automatic step_machine(input instr_t ins, input logic run, input word_t pins,
                            input logic jpin);
  logic [2:0] opc;
  arg_t       a;
  field_t     b;
  logic       taken;
  word_t      val;
  opc = ins[15:13];
  a   = ins[7:5];
  b   = ins[4:0];
  if (!run)
    return;
  if (ref_delay != 0) begin
    ref_delay = ref_delay - 1;
    return;
  end
  if (wait_unmet(ins, pins))
    return;
  taken = (opc == 3'd0) && jump_condition(a, jpin);
  if (taken && a == 3'd2)
    ref_x = ref_x - 1;
  if (taken && a == 3'd4)
    ref_y = ref_y - 1;
  if (opc == 3'd7 || opc == 3'd5) begin
    val = (opc == 3'd7) ? word_t'(b) : mov_source(b, pins);
    case (a)
      3'd0: ref_pins = write_group(ref_pins, val);
      3'd1: ref_x = val;
      3'd2: ref_y = val;
      3'd4: ref_dirs = write_group(ref_dirs, val);
      default: ;
    endcase
  end
  if (taken)
    ref_pc = b;
  else if (ref_pc == wrap_end)
    ref_pc = wrap_target;
  else
    ref_pc = ref_pc + 1;
  ref_delay = ins[12:8];
endtask

`endif

/* tests/tb_top.sv */
// Testbench for the PIO state machine
// Runs a random program with random pins and enable, checked every cycle against a model

`timescale 1ns/10ps
`default_nettype none

module tb_top
  import pio_pkg::*;
;

  localparam int RESET_CYCLES   = 5;
  localparam int NUM_CYCLES     = 2000;
  localparam int TIMEOUT_CYCLES = NUM_CYCLES + NUM_CYCLES / 10;  // Margin for reset

  logic   clk;
  logic   reset;
  logic   en;
  instr_t instr;
  word_t  input_pins;
  logic   jmp_pin;
  pc_t    wrap_target;
  pc_t    wrap_end;
  field_t pins_base;
  field_t in_base;
  arg_t   pins_count;
  pc_t    pc;
  word_t  output_pins;
  word_t  pin_directions;
  logic   exec_stalled;

  instr_t prog_mem [32];
  int     seed = 55;
  int     cycle_count = 0;
  int     cyc;

  `include "pio_model.svh"

  pio_top UUT (
    .clk(clk), .reset(reset), .en(en), .instr(instr), .input_pins(input_pins),
    .jmp_pin(jmp_pin), .wrap_target(wrap_target), .wrap_end(wrap_end),
    .pins_base(pins_base), .in_base(in_base), .pins_count(pins_count),
    .pc(pc), .output_pins(output_pins), .pin_directions(pin_directions),
    .exec_stalled(exec_stalled)
  );

  assign instr = prog_mem[pc];  // Combinational program memory

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: run still going after %0d cycles", cycle_count);
      fail_run();
    end
  end

  task automatic fail_run();
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic value_error(input string name, input word_t got, input word_t exp);
    $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
    fail_run();
  endtask

  task automatic build_program();
    int         i;
    logic [2:0] opc;
    arg_t       a;
    field_t     b;
    for (i = 0; i < 32; i++) begin
      case ($unsigned($random(seed)) % 5)
        0: opc = 3'd0;
        1: opc = 3'd1;
        2: opc = 3'd5;
        3: opc = 3'd7;
        default: opc = 3'd3;  // IN slot, runs as a no-op
      endcase
      a = arg_t'($random(seed));
      b = field_t'($random(seed));
      if (opc == 3'd5 || opc == 3'd7) begin
        case ($unsigned($random(seed)) % 4)
          0: a = 3'd0;
          1: a = 3'd1;
          2: a = 3'd2;
          default: a = 3'd4;
        endcase
      end
      if (opc == 3'd5)
        b[2] = 1'b0;  // Sources pins, X, Y, null
      prog_mem[i] = {opc, 5'($unsigned($random(seed)) % 4), a, b};
    end
    prog_mem[0] = {3'd7, 5'd0, 3'd1, field_t'($random(seed))};  // SET X, no stall at reset
  endtask

  task automatic drive_inputs();
    int r;
    input_pins = word_t'($random(seed));
    r = $random(seed);
    jmp_pin = r[0];
    en = ($unsigned($random(seed)) % 10) < 8;
  endtask

  task automatic check_outputs();
    logic stalled_exp;
    stalled_exp = expect_stalled(prog_mem[ref_pc], input_pins);
    assert (pc === ref_pc) else value_error("pc", word_t'(pc), word_t'(ref_pc));
    assert (output_pins === ref_pins)
      else value_error("output_pins", output_pins, ref_pins);
    assert (pin_directions === ref_dirs)
      else value_error("pin_directions", pin_directions, ref_dirs);
    assert (exec_stalled === stalled_exp)
      else value_error("exec_stalled", word_t'(exec_stalled), word_t'(stalled_exp));
  endtask

  initial begin
    clk         = 1'b0;
    reset       = 1'b1;
    en          = 1'b0;
    input_pins  = '0;
    jmp_pin     = 1'b0;
    wrap_target = 5'd3;
    wrap_end    = 5'd27;   // 28 to 31 only reached by JMP
    pins_base   = 5'd29;   // Group wraps past pin 31
    pins_count  = 3'd5;
    in_base     = 5'd7;
    build_program();
    reset_model();
    repeat (RESET_CYCLES) @(posedge clk);
    #1 reset = 1'b0;
    @(negedge clk);
    assert (pc === '0 && output_pins === '0 && pin_directions === '0 && exec_stalled === 1'b0)
      else begin
        $display("error at %0t: outputs were not cleared by reset", $time);
        fail_run();
      end
    for (cyc = 0; cyc < NUM_CYCLES; cyc++) begin
      @(posedge clk);
      step_machine(prog_mem[ref_pc], en, input_pins, jmp_pin);
      #1 drive_inputs();
      @(negedge clk);
      check_outputs();
    end
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

/* hw/pio_top.sv */
// PIO state machine top level
// Connects the control unit, X and Y scratch registers, operand select and pin unit

`timescale 1ns/10ps
`default_nettype none

module pio_top
  import pio_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   en,
  input  instr_t instr,
  input  word_t  input_pins,
  input  logic   jmp_pin,
  input  pc_t    wrap_target,
  input  pc_t    wrap_end,
  input  field_t pins_base,
  input  field_t in_base,
  input  arg_t   pins_count,
  output pc_t    pc,
  output word_t  output_pins,
  output word_t  pin_directions,
  output logic   exec_stalled
);

  word_t                   new_val;
  word_t                   src_value;
  word_t [NUM_SCRATCH-1:0] scratch_value;
  logic [NUM_SCRATCH-1:0]  scratch_set;
  logic [NUM_SCRATCH-1:0]  scratch_dec;
  arg_t                    op1;
  field_t                  op2;
  logic                    cond_true;
  logic                    pin_level;
  logic                    pin_write;
  logic                    dir_write;

  sm_control control (
    .clk(clk), .reset(reset), .en(en), .instr(instr),
    .wrap_target(wrap_target), .wrap_end(wrap_end),
    .src_value(src_value), .cond_true(cond_true), .pin_level(pin_level),
    .pc(pc), .op1(op1), .op2(op2), .new_val(new_val),
    .scratch_set(scratch_set), .scratch_dec(scratch_dec),
    .pin_write(pin_write), .dir_write(dir_write), .exec_stalled(exec_stalled)
  );

  // X and Y
  for (genvar g = 0; g < NUM_SCRATCH; g++) begin : gen_scratch
    scratch_reg scratch (
      .clk(clk), .reset(reset), .set(scratch_set[g]), .dec(scratch_dec[g]),
      .din(new_val), .value(scratch_value[g])
    );
  end

  operand_select operands (
    .scratch_value(scratch_value), .input_pins(input_pins), .in_base(in_base),
    .jmp_pin(jmp_pin), .op1(op1), .op2(op2),
    .src_value(src_value), .cond_true(cond_true), .pin_level(pin_level)
  );

  pin_unit pins (
    .clk(clk), .reset(reset), .pin_write(pin_write), .dir_write(dir_write),
    .din(new_val), .pins_base(pins_base), .pins_count(pins_count),
    .output_pins(output_pins), .pin_directions(pin_directions)
  );

endmodule

`default_nettype wire

/* hw/sm_control.sv */
// State machine control
// Decodes the current instruction, runs the delay counter and program counter,
// and raises the execution strobes for the scratch registers and pin unit

`timescale 1ns/10ps
`default_nettype none

module sm_control
  import pio_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   en,
  input  instr_t                 instr,
  input  pc_t                    wrap_target,
  input  pc_t                    wrap_end,
  input  word_t                  src_value,
  input  logic                   cond_true,
  input  logic                   pin_level,
  output pc_t                    pc,
  output arg_t                   op1,
  output field_t                 op2,
  output word_t                  new_val,
  output logic [NUM_SCRATCH-1:0] scratch_set,
  output logic [NUM_SCRATCH-1:0] scratch_dec,
  output logic                   pin_write,
  output logic                   dir_write,
  output logic                   exec_stalled
);

  opcode_e opcode;
  field_t  delay_field;
  field_t  delay_cnt;
  logic    delaying;
  logic    waiting;
  logic    execute;
  logic    jump_taken;
  logic    reg_write;
  pc_t     next_pc;

  // Instruction fields
  assign opcode      = opcode_e'(instr[15:13]);
  assign delay_field = instr[12:8];
  assign op1         = instr[7:5];
  assign op2         = instr[4:0];

  assign delaying     = (delay_cnt != '0);
  assign waiting      = (opcode == WAIT) && (pin_level != op1[2]);  // Polarity not yet seen
  assign exec_stalled = delaying || waiting;
  assign execute      = en && !exec_stalled;

  assign jump_taken = (opcode == JMP) && cond_true;
  assign reg_write  = execute && ((opcode == SET) || (opcode == MOV));

  // Taken jump wins over the wrap
  always_comb begin
    if (jump_taken)
      next_pc = pc_t'(op2);
    else if (pc == wrap_end)
      next_pc = wrap_target;
    else
      next_pc = pc + 1'b1;
  end

  always_comb begin
    new_val     = '0;
    scratch_set = '0;
    scratch_dec = '0;
    pin_write   = 1'b0;
    dir_write   = 1'b0;

    case (opcode)
      SET:     new_val = word_t'(op2);  // Zero extended
      MOV:     new_val = src_value;
      default: new_val = '0;
    endcase

    if (execute && jump_taken) begin
      scratch_dec[0] = (op1 == COND_X_DEC);  // Post-decrement X
      scratch_dec[1] = (op1 == COND_Y_DEC);  // Post-decrement Y
    end

    if (reg_write) begin
      case (op1)
        DST_PINS:    pin_write      = 1'b1;
        DST_X:       scratch_set[0] = 1'b1;
        DST_Y:       scratch_set[1] = 1'b1;
        DST_PINDIRS: dir_write      = 1'b1;
        default:     pin_write      = 1'b0;  // Reserved destination
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc        <= '0;
      delay_cnt <= '0;
    end else if (en) begin
      if (delaying) begin
        delay_cnt <= delay_cnt - 1'b1;
      end else if (!waiting) begin
        delay_cnt <= delay_field;  // Instruction completes here
        pc        <= next_pc;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/pin_unit.sv */
// Pin unit
// Output pin and direction registers, written as a base/count group of up to five pins

`timescale 1ns/10ps
`default_nettype none

module pin_unit
  import pio_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   pin_write,
  input  logic   dir_write,
  input  word_t  din,
  input  field_t pins_base,
  input  arg_t   pins_count,
  output word_t  output_pins,
  output word_t  pin_directions
);

  word_t group_mask;
  word_t group_data;

  // Spread din over the group, wrapping past pin 31
  always_comb begin
    group_mask = '0;
    group_data = '0;
    for (int i = 0; i < PIN_GROUP_MAX; i++) begin
      if (i < pins_count) begin
        group_mask[field_t'(pins_base + i)] = 1'b1;
        group_data[field_t'(pins_base + i)] = din[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      output_pins    <= '0;
      pin_directions <= '0;
    end else begin
      if (pin_write)
        output_pins <= (output_pins & ~group_mask) | group_data;
      if (dir_write)
        pin_directions <= (pin_directions & ~group_mask) | group_data;
    end
  end

endmodule

`default_nettype wire

/* hw/operand_select.sv */
// Operand select
// MOV source with bit operation, JMP condition and WAIT pin level, all combinational

`timescale 1ns/10ps
`default_nettype none

module operand_select
  import pio_pkg::*;
(
  input  word_t [NUM_SCRATCH-1:0] scratch_value,
  input  word_t                   input_pins,
  input  field_t                  in_base,
  input  logic                    jmp_pin,
  input  arg_t                    op1,
  input  field_t                  op2,
  output word_t                   src_value,
  output logic                    cond_true,
  output logic                    pin_level
);

  word_t       x;
  word_t       y;
  logic [63:0] pins_rot;
  word_t       in_pins;
  word_t       raw_value;

  assign x = scratch_value[0];
  assign y = scratch_value[1];

  // Rotate right so pin in_base lands on bit 0
  assign pins_rot = {input_pins, input_pins} >> in_base;
  assign in_pins  = pins_rot[31:0];

  always_comb begin
    case (op2[2:0])
      SRC_PINS: raw_value = in_pins;
      SRC_X:    raw_value = x;
      SRC_Y:    raw_value = y;
      SRC_NULL: raw_value = '0;
      default:  raw_value = '0;  // Sources not present here read as zero
    endcase
  end

  always_comb begin
    case (op2[4:3])
      BITOP_INVERT:  src_value = ~raw_value;
      BITOP_REVERSE: src_value = {<<{raw_value}};
      default:       src_value = raw_value;  // Includes reserved code 3
    endcase
  end

  always_comb begin
    case (op1)
      COND_ALWAYS: cond_true = 1'b1;
      COND_X_ZERO: cond_true = (x == '0);
      COND_X_DEC:  cond_true = (x != '0);
      COND_Y_ZERO: cond_true = (y == '0);
      COND_Y_DEC:  cond_true = (y != '0);
      COND_X_NE_Y: cond_true = (x != y);
      COND_PIN:    cond_true = jmp_pin;
      default:     cond_true = 1'b0;
    endcase
  end

  // WAIT uses the absolute GPIO number
  assign pin_level = input_pins[op2];

endmodule

`default_nettype wire

/* hw/scratch_reg.sv */
// Scratch register
// One 32-bit register with parallel load and decrement by one

`timescale 1ns/10ps
`default_nettype none

module scratch_reg
  import pio_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  set,
  input  logic  dec,
  input  word_t din,
  output word_t value
);

  always_ff @(posedge clk) begin
    if (reset)
      value <= '0;
    else if (set)
      value <= din;
    else if (dec)
      value <= value - 1'b1;  // Wraps at zero
  end

endmodule

`default_nettype wire

/* hw/pio_pkg.sv */
// PIO package
// Widths, instruction field types, opcode and field codes for the state machine

`default_nettype none

package pio_pkg;

  typedef logic [31:0] word_t;   // Scratch values and pin words
  typedef logic [4:0]  pc_t;     // Program address
  typedef logic [15:0] instr_t;  // Instruction word
  typedef logic [4:0]  field_t;  // op2, delay, pin base, GPIO index
  typedef logic [2:0]  arg_t;    // op1 and pin count

  // Opcodes outside this set run as no-ops
  typedef enum logic [2:0] {
    JMP  = 3'd0,
    WAIT = 3'd1,
    MOV  = 3'd5,
    SET  = 3'd7
  } opcode_e;

  localparam int NUM_SCRATCH   = 2;  // X at index 0, Y at index 1
  localparam int PIN_GROUP_MAX = 5;

  // JMP conditions
  localparam arg_t COND_ALWAYS = 3'd0;
  localparam arg_t COND_X_ZERO = 3'd1;
  localparam arg_t COND_X_DEC  = 3'd2;  // X nonzero, then X--
  localparam arg_t COND_Y_ZERO = 3'd3;
  localparam arg_t COND_Y_DEC  = 3'd4;  // Y nonzero, then Y--
  localparam arg_t COND_X_NE_Y = 3'd5;
  localparam arg_t COND_PIN    = 3'd6;

  // MOV sources
  localparam logic [2:0] SRC_PINS = 3'd0;
  localparam logic [2:0] SRC_X    = 3'd1;
  localparam logic [2:0] SRC_Y    = 3'd2;
  localparam logic [2:0] SRC_NULL = 3'd3;

  // MOV and SET destinations
  localparam arg_t DST_PINS    = 3'd0;
  localparam arg_t DST_X       = 3'd1;
  localparam arg_t DST_Y       = 3'd2;
  localparam arg_t DST_PINDIRS = 3'd4;

  // MOV bit operations
  localparam logic [1:0] BITOP_NONE    = 2'd0;
  localparam logic [1:0] BITOP_INVERT  = 2'd1;
  localparam logic [1:0] BITOP_REVERSE = 2'd2;

endpackage

`default_nettype wire
